/* hw/prefetch_pkg.sv */
package prefetch_pkg;

   // --------------------
   // Bus bundles.
   // --------------------

   localparam int DATA_W = 32;  // Bus data width.

   // Master to slave, pipelined Wishbone B4 read.
   typedef struct packed {
      logic        cyc;  // Cycle in progress.
      logic        stb;  // Request valid.
      logic [15:0] adr;  // Word address.
   } wb_m2s_t;

   // Slave to master.
   typedef struct packed {
      logic              ack;    // Read data valid.
      logic              stall;  // Request not taken this cycle.
      logic              err;    // Request failed.
      logic [DATA_W-1:0] dat;    // Read data.
   } wb_s2m_t;

   // --------------------
   // Configuration words.
   // --------------------

   // Control view of a write word.
   typedef struct packed {
      logic [22:0] rsvd;   // Ignored on write.
      logic [7:0]  len;    // Block length in words.
      logic        start;  // Launch a block.
   } cfg_ctrl_t;

   // Base address view of a write word.
   typedef struct packed {
      logic [15:0] rsvd;  // Ignored on write.
      logic [15:0] addr;  // First word address.
   } cfg_base_t;

   // One write word, decoded by register index.
   typedef union packed {
      cfg_base_t base;
      cfg_ctrl_t ctrl;
   } cfg_word_u;

   // Status read word.
   typedef struct packed {
      logic [21:0] rsvd;
      logic [7:0]  done_cnt;  // Completed blocks, wraps.
      logic        err;       // Last block aborted.
      logic        busy;      // Fetch in progress.
   } status_t;

   // Register indices.
   localparam logic [1:0] REG_BASE   = 2'd0;
   localparam logic [1:0] REG_CTRL   = 2'd1;
   localparam logic [1:0] REG_STATUS = 2'd2;

endpackage

/* hw/fetch_cfg_regs.sv */
module fetch_cfg_regs import prefetch_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        cfg_wr_i,     // Register write strobe.
   input  logic [1:0]  cfg_addr_i,   // Register index.
   input  cfg_word_u   cfg_wdata_i,  // Write word.
   input  logic        busy_i,       // Fetch engine busy.
   input  logic        done_i,       // Block finished.
   input  logic        err_i,        // Block aborted.
   output logic [31:0] cfg_rdata_o,  // Read word for cfg_addr_i.
   output logic        start_o,      // Launch pulse.
   output logic [15:0] base_o,
   output logic [7:0]  len_o
);

   logic [15:0] base_q;      // Base address register.
   logic [7:0]  len_q;       // Length of the last accepted block.
   logic        err_q;       // Sticky abort flag.
   logic [7:0]  done_cnt_q;  // Completed blocks.
   logic        ctrl_wr;
   status_t     status;

   // --------------------
   // Start decode.
   // --------------------

   assign ctrl_wr = cfg_wr_i && (cfg_addr_i == REG_CTRL);

   // Accepted only while idle, and a zero length is not a block.
   assign start_o = ctrl_wr && cfg_wdata_i.ctrl.start &&
                    (cfg_wdata_i.ctrl.len != 8'd0) && !busy_i;

   assign base_o = base_q;
   // The length travels with the start pulse itself.
   assign len_o  = start_o ? cfg_wdata_i.ctrl.len : len_q;

   // --------------------
   // Registers.
   // --------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         base_q     <= '0;
         len_q      <= '0;
         err_q      <= 1'b0;
         done_cnt_q <= '0;
      end else begin
         if (cfg_wr_i && (cfg_addr_i == REG_BASE)) begin
            base_q <= cfg_wdata_i.base.addr;  // Low half only.
         end
         if (start_o) begin
            len_q <= cfg_wdata_i.ctrl.len;
            err_q <= 1'b0;  // A new block clears the old abort.
         end else if (err_i) begin
            err_q <= 1'b1;
         end
         if (done_i) begin
            done_cnt_q <= done_cnt_q + 8'd1;  // Wraps at 256.
         end
      end
   end

   // Read mux.
   assign status = '{rsvd: '0, done_cnt: done_cnt_q, err: err_q, busy: busy_i};

   always_comb begin
      case (cfg_addr_i)
         REG_BASE:   cfg_rdata_o = {16'd0, base_q};
         REG_CTRL:   cfg_rdata_o = {23'd0, len_q, 1'b0};  // Start reads as zero.
         REG_STATUS: cfg_rdata_o = status;
         default:    cfg_rdata_o = '0;
      endcase
   end

   // Start only from idle, and the fetch engine picks it up next cycle.
   a_start_idle : assert property (@(posedge clk_i) disable iff (rst_i)
      start_o |-> !busy_i ##1 busy_i);

endmodule

/* hw/wb_block_fetch.sv */
module wb_block_fetch import prefetch_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              start_i,        // Launch pulse.
   input  logic [15:0]       base_i,         // First address.
   input  logic [7:0]        len_i,          // Words in the block.
   input  wb_s2m_t           wb_i,
   input  logic              fill_credit_i,  // One buffer slot freed.
   output wb_m2s_t           wb_o,
   output logic              busy_o,
   output logic              done_o,         // Block complete.
   output logic              err_o,          // Block aborted.
   output logic [DATA_W-1:0] wdata_o,        // Word to the buffer.
   output logic              wvalid_o
);

   logic        cyc_q;
   logic        stb_q;
   logic [15:0] adr_q;
   logic [7:0]  req_q;  // Requests still to issue.
   logic [7:0]  out_q;  // Acks still owed.
   logic [7:0]  crd_q;  // Buffer slots held, up to BUF_DEPTH.
   logic        cyc_d;
   logic        stb_d;
   logic [7:0]  req_d;
   logic [7:0]  out_d;
   logic [7:0]  crd_d;
   logic        xfer;   // Request taken by the slave.
   logic        ack;
   logic        err;
   logic        last;   // Final owed ack of the block.

   // --------------------
   // Bus events.
   // --------------------

   assign xfer = cyc_q && stb_q && !wb_i.stall;
   assign ack  = cyc_q && wb_i.ack;  // Responses after an abort are dropped.
   assign err  = cyc_q && wb_i.err;
   assign last = ack && (out_q == 8'd1) && (req_q == 8'd0);

   // --------------------
   // Next state.
   // --------------------

   always_comb begin
      cyc_d = cyc_q;
      req_d = req_q;
      out_d = out_q;
      crd_d = crd_q + {7'd0, fill_credit_i};
      if (start_i) begin
         cyc_d = 1'b1;  // Register block only starts from idle.
         req_d = len_i;
      end else if (err) begin
         // Abort. Slots of the lost requests go back to the pool.
         cyc_d = 1'b0;
         req_d = 8'd0;
         out_d = 8'd0;
         crd_d = crd_d + out_q;
      end else begin
         if (xfer) begin
            req_d = req_q - 8'd1;
            crd_d = crd_d - 8'd1;  // One slot per request.
         end
         case ({xfer, ack})
            2'b10:   out_d = out_q + 8'd1;
            2'b01:   out_d = out_q - 8'd1;
            default: out_d = out_q;
         endcase
         if (last) begin
            cyc_d = 1'b0;  // Everything answered.
         end
      end
      // Strobe only with work left and a slot in hand.
      stb_d = cyc_d && (req_d != 8'd0) && (crd_d != 8'd0);
   end

   // --------------------
   // State registers.
   // --------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cyc_q  <= 1'b0;
         stb_q  <= 1'b0;
         req_q  <= '0;
         out_q  <= '0;
         crd_q  <= '0;  // Buffer hands out its slots after reset.
         done_o <= 1'b0;
         err_o  <= 1'b0;
      end else begin
         cyc_q  <= cyc_d;
         stb_q  <= stb_d;
         req_q  <= req_d;
         out_q  <= out_d;
         crd_q  <= crd_d;
         done_o <= last;  // One cycle after the final ack.
         err_o  <= err;
      end
   end

   // Address counter.
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         adr_q <= base_i;
      end else if (xfer) begin
         adr_q <= adr_q + 16'd1;  // No wrap handling inside a block.
      end
   end

   assign wb_o     = '{cyc: cyc_q, stb: stb_q, adr: adr_q};
   assign busy_o   = cyc_q;
   assign wdata_o  = wb_i.dat;
   assign wvalid_o = ack;  // Forwarded the same cycle.

   // The slave answers only requests it actually took.
   a_ack_owed : assert property (@(posedge clk_i) disable iff (rst_i)
      ack |-> (out_q != 8'd0));

endmodule

/* hw/block_buffer.sv */
module block_buffer import prefetch_pkg::*; #(
   parameter int BUF_DEPTH   = 16,  // Words, power of two.
   parameter int OUT_CREDITS = 4    // Initial consumer credits.
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [DATA_W-1:0] wdata_i,        // Word from the fetch engine.
   input  logic              wvalid_i,
   input  logic              out_credit_i,   // Consumer returns one credit.
   output logic              fill_credit_o,  // One slot to the fetch engine.
   output logic [DATA_W-1:0] out_data_o,
   output logic              out_valid_o
);

   localparam int         AW   = $clog2(BUF_DEPTH);
   localparam int         CW   = $clog2(OUT_CREDITS + 1);
   localparam logic [AW:0] FULL = (AW + 1)'(BUF_DEPTH);

   logic [DATA_W-1:0] mem_q [BUF_DEPTH];  // Word storage.
   logic [AW-1:0]     wr_ptr_q;
   logic [AW-1:0]     rd_ptr_q;
   logic [AW:0]       cnt_q;    // Words held.
   logic [AW:0]       fpend_q;  // Fill credits not yet handed out.
   logic [CW-1:0]     ocrd_q;   // Consumer credits held.
   logic              push;
   logic              pop;

   assign push = wvalid_i;
   assign pop  = (cnt_q != '0) && (ocrd_q != '0);  // Word and credit both present.

   assign out_valid_o   = pop;
   assign out_data_o    = mem_q[rd_ptr_q];
   assign fill_credit_o = (fpend_q != '0);  // At most one per cycle.

   // --------------------
   // Storage.
   // --------------------

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= wdata_i;
      end
   end

   // --------------------
   // Pointers and counts.
   // --------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
         fpend_q  <= FULL;                    // Whole buffer is free.
         ocrd_q   <= CW'(OUT_CREDITS);
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;      // Wraps at the depth.
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;
         endcase
         // A slot sent out becomes a fill credit.
         case ({pop, fill_credit_o})
            2'b10:   fpend_q <= fpend_q + 1'b1;
            2'b01:   fpend_q <= fpend_q - 1'b1;
            default: fpend_q <= fpend_q;
         endcase
         case ({out_credit_i, pop})
            2'b10:   ocrd_q <= ocrd_q + 1'b1;
            2'b01:   ocrd_q <= ocrd_q - 1'b1;
            default: ocrd_q <= ocrd_q;
         endcase
      end
   end

   // The fetch engine never writes past its fill credits.
   a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
      push |-> (cnt_q != FULL));

   // The consumer never returns more than it was sent.
   a_ocrd_bound : assert property (@(posedge clk_i) disable iff (rst_i)
      ocrd_q <= CW'(OUT_CREDITS));

endmodule

/* hw/prefetch_top.sv */
module prefetch_top import prefetch_pkg::*; #(
   parameter int BUF_DEPTH   = 16,  // Power of two, at most 128.
   parameter int OUT_CREDITS = 4
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              cfg_wr_i,
   input  logic [1:0]        cfg_addr_i,
   input  cfg_word_u         cfg_wdata_i,
   output logic [31:0]       cfg_rdata_o,
   input  wb_s2m_t           wb_i,
   output wb_m2s_t           wb_o,
   input  logic              out_credit_i,
   output logic [DATA_W-1:0] out_data_o,
   output logic              out_valid_o
);

   // --------------------
   // Internal links.
   // --------------------

   logic              start;        // Launch, register block to fetch engine.
   logic [15:0]       base;
   logic [7:0]        len;
   logic              busy;
   logic              done_pulse;
   logic              err_pulse;
   logic [DATA_W-1:0] wdata;        // Fetched word to the buffer.
   logic              wvalid;
   logic              fill_credit;  // Freed slot back to the fetch engine.

   fetch_cfg_regs u_cfg (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_wr_i    (cfg_wr_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .busy_i      (busy),
      .done_i      (done_pulse),
      .err_i       (err_pulse),
      .cfg_rdata_o (cfg_rdata_o),
      .start_o     (start),
      .base_o      (base),
      .len_o       (len)
   );

   wb_block_fetch u_fetch (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .start_i       (start),
      .base_i        (base),
      .len_i         (len),
      .wb_i          (wb_i),
      .fill_credit_i (fill_credit),
      .wb_o          (wb_o),
      .busy_o        (busy),
      .done_o        (done_pulse),
      .err_o         (err_pulse),
      .wdata_o       (wdata),
      .wvalid_o      (wvalid)
   );

   block_buffer #(
      .BUF_DEPTH   (BUF_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) u_buf (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .wdata_i       (wdata),
      .wvalid_i      (wvalid),
      .out_credit_i  (out_credit_i),
      .fill_credit_o (fill_credit),
      .out_data_o    (out_data_o),
      .out_valid_o   (out_valid_o)
   );

endmodule

/* tb/tb_clkgen.sv */
module tb_clkgen #(
   parameter int HALF_PERIOD = 10,  // 20-unit clock period.
   parameter int RST_CYCLES  = 8
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Reset held for a fixed number of rising edges.
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      #2 rst_o = 1'b0;  // Released with the rest of the stimulus.
   end

endmodule

/* tb/wb_mem_model.sv */
module wb_mem_model import prefetch_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  wb_m2s_t     wb_i,
   input  logic        stall_bit_i,  // Random bit from the testbench.
   input  logic        stall_en_i,
   input  logic        err_en_i,
   input  logic [15:0] err_adr_i,    // Address that answers with err.
   output wb_s2m_t     wb_o
);

   // --------------------
   // Response pipeline.
   // --------------------

   logic [1:0]        vld_q;  // Request taken, per stage.
   logic [1:0]        bad_q;  // Request answers with err.
   logic [1:0][15:0]  adr_q;
   logic              stall;
   logic              take;

   assign stall = stall_en_i && stall_bit_i;
   assign take  = wb_i.cyc && wb_i.stb && !stall;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vld_q <= '0;
         bad_q <= '0;
      end else begin
         vld_q <= {vld_q[0], take};                                  // Two cycles of latency.
         bad_q <= {bad_q[0], err_en_i && (wb_i.adr == err_adr_i)};
      end
      adr_q[1] <= adr_q[0];
      adr_q[0] <= wb_i.adr;
   end

   // Responses are dropped once the master ends the cycle.
   assign wb_o.ack   = vld_q[1] && !bad_q[1] && wb_i.cyc;
   assign wb_o.err   = vld_q[1] && bad_q[1] && wb_i.cyc;
   assign wb_o.stall = stall;
   // Memory word: complement of the address above the address.
   assign wb_o.dat   = {~adr_q[1], adr_q[1]};

endmodule

/* tb/prefetch_tb.sv */
module prefetch_tb import prefetch_pkg::*;;

   localparam int BUF_DEPTH   = 16;
   localparam int OUT_CREDITS = 4;
   localparam int WORDS       = 12 + 16 + 16 + 8 + 8 + 4;  // All blocks of the run.
   localparam int LIMIT       = WORDS * 40 + 200;

   logic        clk_i;
   logic        rst_i;
   logic        cfg_wr_i;
   logic [1:0]  cfg_addr_i;
   cfg_word_u   cfg_wdata_i;
   logic [31:0] cfg_rdata_o;
   wb_s2m_t     wb_i;
   wb_m2s_t     wb_o;
   logic        out_credit_i;
   logic [31:0] out_data_o;
   logic        out_valid_o;

   logic        stall_bit;   // Random stall request to the memory.
   logic        stall_en;
   logic        err_en;
   logic [15:0] err_adr;
   logic        hold;        // Consumer keeps its credits.
   logic        pre_write;   // No register written yet.
   logic [15:0] blk_base;
   int          blk_first;   // out_total at block start.
   int          req_first;
   int          out_total;   // Words seen on the output.
   int          req_total;   // Bus requests transferred.
   int          bal;         // Credits held by the buffer, as the consumer sees it.
   int          owed;        // Credits still to return.
   int          gap;
   int          cycles;
   int          bus_errs;
   int          seq_errs;
   logic [31:0] lfsr;
   logic [15:0] exp_adr;
   logic [31:0] exp_word;

   tb_clkgen u_clkgen (.clk_o(clk_i), .rst_o(rst_i));

   prefetch_top #(
      .BUF_DEPTH   (BUF_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) u_prefetch_top (
      .clk_i, .rst_i, .cfg_wr_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
      .wb_i, .wb_o, .out_credit_i, .out_data_o, .out_valid_o
   );

   wb_mem_model u_mem (
      .clk_i, .rst_i, .wb_i(wb_o), .stall_bit_i(stall_bit), .stall_en_i(stall_en),
      .err_en_i(err_en), .err_adr_i(err_adr), .wb_o(wb_i)
   );

   // --------------------
   // Random bits.
   // --------------------

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois taps.
   endfunction

   // Expected word, from the memory rule.
   assign exp_adr  = blk_base + 16'(out_total - blk_first);
   assign exp_word = {~exp_adr, exp_adr};

   // Output and bus monitors.
   always @(posedge clk_i) begin
      if (out_valid_o) out_total <= out_total + 1;
      if (wb_o.cyc && wb_o.stb && !wb_i.stall) req_total <= req_total + 1;
   end

   // Credit return and stall bits, driven after the edge.
   always @(posedge clk_i) begin
      logic got;
      got = out_valid_o && !rst_i;
      #2;
      out_credit_i = 1'b0;
      lfsr = lfsr_step(lfsr);
      stall_bit = lfsr[0];
      if (got) begin
         owed = owed + 1;
         bal  = bal - 1;
      end
      if (rst_i) begin
         owed = 0;
         gap  = 0;
         bal  = OUT_CREDITS;
      end else if (!hold && owed != 0) begin
         if (gap == 0) begin
            out_credit_i = 1'b1;
            owed = owed - 1;
            bal  = bal + 1;
            lfsr = lfsr_step(lfsr);
            gap  = lfsr[0];                      // Two bits of gap.
            lfsr = lfsr_step(lfsr);
            gap  = gap + 2 * lfsr[0];
         end else begin
            gap = gap - 1;
         end
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout, the run took more than %0d cycles.", LIMIT);
         $display("tests failed");
         $finish;
      end
   end

   // --------------------
   // Assertions.
   // --------------------

   a_idle : assert property (@(posedge clk_i) disable iff (rst_i)
      pre_write |-> (!wb_o.cyc && !wb_o.stb && !out_valid_o))
      else begin
         bus_errs++;
         $display("Bus or output became active before any register write.");
      end

   a_data : assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o |-> (out_data_o == exp_word))
      else begin
         bus_errs++;
         $display("[ERROR] out_data_o got %h expected %h",
                  $sampled(out_data_o), $sampled(exp_word));
      end

   a_credit : assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o |-> (bal > 0))
      else begin
         bus_errs++;
         $display("Word sent while the consumer held no credit.");
      end

   // --------------------
   // Sequence tasks.
   // --------------------

   task automatic write_reg(input logic [1:0] adr, input cfg_word_u w);
      cfg_wr_i    = 1'b1;
      cfg_addr_i  = adr;
      cfg_wdata_i = w;
      @(posedge clk_i);
      #2;
      cfg_wr_i   = 1'b0;
      cfg_addr_i = REG_STATUS;  // Status stays readable.
   endtask

   task automatic start_block(input logic [15:0] base, input logic [7:0] len);
      cfg_word_u w;
      pre_write = 1'b0;
      blk_base  = base;
      blk_first = out_total;
      req_first = req_total;
      w = '0;
      w.base.addr = base;
      write_reg(REG_BASE, w);
      w = '0;
      w.ctrl.start = 1'b1;
      w.ctrl.len   = len;
      write_reg(REG_CTRL, w);
   endtask

   task automatic finish_block(input int words);
      @(negedge clk_i);
      while (cfg_rdata_o[0]) @(negedge clk_i);          // Busy.
      while (out_total - blk_first != words) @(negedge clk_i);
      @(posedge clk_i);
      #2;
   endtask

   task automatic check_status(input logic busy, input logic err, input logic [7:0] cnt);
      status_t s;
      @(negedge clk_i);
      s = status_t'(cfg_rdata_o);
      assert (s.busy == busy && s.err == err && s.done_cnt == cnt)
         else begin
            seq_errs++;
            $display("[ERROR] cfg_rdata_o got %h expected busy %h err %h count %h",
                     cfg_rdata_o, busy, err, cnt);
         end
      @(posedge clk_i);
      #2;
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      assert (got == exp)
         else begin
            seq_errs++;
            $display("[ERROR] %s got %h expected %h", what, got, exp);
         end
   endtask

   // --------------------
   // Test sequence.
   // --------------------

   initial begin
      cfg_wr_i     = 1'b0;
      cfg_addr_i   = REG_STATUS;
      cfg_wdata_i  = '0;
      out_credit_i = 1'b0;
      stall_bit    = 1'b0;
      stall_en     = 1'b0;
      err_en       = 1'b0;
      err_adr      = '0;
      hold         = 1'b0;
      pre_write    = 1'b1;
      blk_base     = '0;
      blk_first    = 0;
      req_first    = 0;
      out_total    = 0;
      req_total    = 0;
      bal          = OUT_CREDITS;
      owed         = 0;
      gap          = 0;
      cycles       = 0;
      bus_errs     = 0;
      seq_errs     = 0;
      lfsr         = 32'hd484;
      @(negedge rst_i);
      @(posedge clk_i);
      #2;
      repeat (10) @(posedge clk_i);                     // Idle after reset.
      #2;
      check_status(1'b0, 1'b0, 8'd0);

      start_block(16'h0100, 8'd12);                     // Plain block.
      finish_block(12);
      check_count("req count", req_total - req_first, 12);
      check_status(1'b0, 1'b0, 8'd1);

      stall_en = 1'b1;                                  // Bus stalls.
      start_block(16'h0200, 8'd16);
      finish_block(16);
      check_count("req count", req_total - req_first, 16);
      check_status(1'b0, 1'b0, 8'd2);

      @(negedge clk_i);
      while (owed != 0) @(negedge clk_i);               // All credits back first.
      hold = 1'b1;                                      // Consumer back-pressure.
      @(posedge clk_i);
      #2;
      start_block(16'h0300, 8'd16);
      repeat (60) @(posedge clk_i);
      #2;
      check_count("held out count", out_total - blk_first, OUT_CREDITS);
      @(negedge clk_i);
      hold = 1'b0;
      finish_block(16);
      check_status(1'b0, 1'b0, 8'd3);

      start_block(16'h0400, 8'd8);                      // Start while busy.
      start_block(16'h0500, 8'd8);
      blk_base  = 16'h0400;
      blk_first = out_total;
      finish_block(8);
      repeat (20) @(posedge clk_i);
      #2;
      check_count("out count", out_total - blk_first, 8);
      check_status(1'b0, 1'b0, 8'd4);

      err_en  = 1'b1;                                   // Abort on the fourth word.
      err_adr = 16'h0603;
      start_block(16'h0600, 8'd8);
      finish_block(3);
      repeat (10) @(posedge clk_i);
      #2;
      check_count("out count", out_total - blk_first, 3);
      check_status(1'b0, 1'b1, 8'd4);
      err_en = 1'b0;
      start_block(16'h0700, 8'd4);
      finish_block(4);
      check_status(1'b0, 1'b0, 8'd5);

      $display("Errors: %0d in assertions, %0d in sequence checks.", bus_errs, seq_errs);
      if (bus_errs == 0 && seq_errs == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* flist.f */
hw/prefetch_pkg.sv
hw/fetch_cfg_regs.sv
hw/wb_block_fetch.sv
hw/block_buffer.sv
hw/prefetch_top.sv
tb/tb_clkgen.sv
tb/wb_mem_model.sv
tb/prefetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the prefetch testbench with Verilator.
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -j 0 --top-module prefetch_tb \
      -f flist.f -o sim 2>&1 && ./obj_dir/sim 2>&1)

echo "$out"
grep -q "all tests passed" <<< "$out" && echo "PASS" || { echo "FAIL"; exit 1; }
